// File: logic/ov7670_pkg.sv
/*
  ov7670 colour tracker package
  shared pixel, camera byte, filter select and centroid types,
  plus the fixed histogram and threshold constants
*/

package ov7670_pkg;

  // one byte of the camera data port
  typedef logic [7:0] cam_byte_t;

  // buffered pixel, rgb444: red [11:8], green [7:4], blue [3:0]
  typedef logic [11:0] pxl_t;

  // one colour channel of a buffered pixel
  typedef logic [3:0] nibble_t;

  // colour filter select, value 3 means no filter
  typedef logic [1:0] color_sel_t;

  localparam color_sel_t c_sel_red   = 2'd0;
  localparam color_sel_t c_sel_green = 2'd1;
  localparam color_sel_t c_sel_blue  = 2'd2;

  // number of column bins of the histogram
  // fixed at 8 since the centroid goes out decoded, one bit per bin
  localparam int c_hist_bins = 8;

  // decoded centroid, bit i set when the median falls in bin i
  typedef logic [c_hist_bins-1:0] centroid_t;

  // a channel is "on" at or above this value, "off" below it
  localparam nibble_t c_color_thresh = 4'd8;

endpackage

// File: logic/ov7670_capture.sv
/*
  ov7670 capture
  samples the camera strobes in the clk domain, packs rgb565 byte pairs
  into rgb444 words for the frame buffer and flags each frame end
*/

module ov7670_capture
  #(parameter  c_img_cols    = 160,
    parameter  c_img_rows    = 120,
    localparam c_img_pxls    = c_img_cols * c_img_rows,
    localparam c_nb_img_pxls = $clog2(c_img_pxls))
  (input  logic                     clk,
   input  logic                     arst_n_i,
   input  logic                     pclk_i,   // camera pixel clock, async to clk
   input  logic                     vsync_i,
   input  logic                     href_i,
   input  ov7670_pkg::cam_byte_t    data_i,
   output logic                     we_o,     // one pulse per pixel
   output logic [c_nb_img_pxls-1:0] addr_o,   // raster order
   output ov7670_pkg::pxl_t         pxl_o,
   output logic                     frame_end_o);

  import ov7670_pkg::*;

  localparam logic [c_nb_img_pxls-1:0] c_last_addr = c_nb_img_pxls'(c_img_pxls - 1);

  logic [2:0] pclk_sr;   // 2 sync flops + 1 for edge detection
  logic [2:0] vsync_sr;
  logic [1:0] href_sr;
  cam_byte_t  data_d1;   // data delayed like the strobes, so they stay aligned
  cam_byte_t  data_d2;
  logic       pclk_rise;
  logic       vsync_rise;
  logic       take_byte;
  logic       byte_odd_q; // 0: first byte of the pair
  nibble_t    red_q;
  logic [2:0] grn_hi_q;   // green [5:3] from the first byte
  logic       written_q;  // some pixel written since last frame end

  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      pclk_sr  <= '0;
      vsync_sr <= '0;
      href_sr  <= '0;
    end else begin
      pclk_sr  <= {pclk_sr[1:0], pclk_i};
      vsync_sr <= {vsync_sr[1:0], vsync_i};
      href_sr  <= {href_sr[0], href_i};
    end
  end

  always_ff @(posedge clk) begin
    data_d1 <= data_i;
    data_d2 <= data_d1; // same delay as pclk_sr[1]
  end

  assign pclk_rise  = pclk_sr[1] & ~pclk_sr[2];
  assign vsync_rise = vsync_sr[1] & ~vsync_sr[2];
  assign take_byte  = pclk_rise & href_sr[1]; // bytes only count inside a line

  // byte phase and write strobe
  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      byte_odd_q <= 1'b0;
      we_o       <= 1'b0;
    end else begin
      we_o <= 1'b0;
      if (vsync_sr[1]) begin
        byte_odd_q <= 1'b0; // realign to first byte on each frame
      end else if (take_byte) begin
        byte_odd_q <= ~byte_odd_q;
        we_o       <= byte_odd_q; // pixel done with the second byte
      end
    end
  end

  // pixel assembly, keep top 4 bits of each channel
  always_ff @(posedge clk) begin
    if (take_byte && !vsync_sr[1]) begin
      if (!byte_odd_q) begin
        red_q    <= data_d2[7:4]; // R[4:1]
        grn_hi_q <= data_d2[2:0]; // G[5:3]
      end else begin
        pxl_o <= {red_q, grn_hi_q, data_d2[7], data_d2[4:1]}; // G[2], B[4:1]
      end
    end
  end

  // write address, steps after each write and sticks at the last pixel
  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      addr_o <= '0;
    end else if (vsync_sr[1]) begin
      addr_o <= '0;
    end else if (we_o && addr_o != c_last_addr) begin
      addr_o <= addr_o + 1'b1;
    end
  end

  // frame end only when a frame was really written
  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      written_q   <= 1'b0;
      frame_end_o <= 1'b0;
    end else begin
      frame_end_o <= vsync_rise & written_q;
      if (vsync_rise)
        written_q <= 1'b0;
      else if (we_o)
        written_q <= 1'b1;
    end
  end

endmodule

// File: logic/frame_buffer.sv
/*
  frame buffer
  simple dual port image memory, one write port from the capture
  and one registered read port for the processing
*/

module frame_buffer
  #(parameter  c_img_pxls = 19200,          // cols x rows
    localparam c_nb_addr  = $clog2(c_img_pxls))
  (input  logic                 clk,
   input  logic                 we_i,
   input  logic [c_nb_addr-1:0] waddr_i,
   input  ov7670_pkg::pxl_t     wdata_i,
   input  logic [c_nb_addr-1:0] raddr_i,
   output ov7670_pkg::pxl_t     rdata_o);  // valid one cycle after raddr_i

  import ov7670_pkg::*;

  pxl_t mem [c_img_pxls]; // maps to block ram

  // write port
  always_ff @(posedge clk) begin
    if (we_i)
      mem[waddr_i] <= wdata_i;
  end

  // read port, registered output
  always_ff @(posedge clk) begin
    rdata_o <= mem[raddr_i];
  end

endmodule

// File: logic/color_proc.sv
/*
  colour processing
  after each frame end scans the inner frame of the buffered image,
  classifies every pixel against the selected colour filter and
  counts the matches in total and per column bin
*/

module color_proc
  #(parameter  c_img_cols      = 160,
    parameter  c_img_rows      = 120,
    parameter  c_outframe_cols = 16,  // columns dropped at each side
    parameter  c_outframe_rows = 8,   // rows dropped at top and bottom
    localparam c_img_pxls      = c_img_cols * c_img_rows,
    localparam c_nb_img_pxls   = $clog2(c_img_pxls),
    localparam c_in_cols       = c_img_cols - 2 * c_outframe_cols,
    localparam c_in_rows       = c_img_rows - 2 * c_outframe_rows,
    localparam c_bin_cols      = c_in_cols / ov7670_pkg::c_hist_bins,
    localparam c_nb_colorpxls  = $clog2(c_in_cols * c_in_rows + 1),
    localparam c_nb_bin_cnt    = $clog2(c_in_rows * c_bin_cols + 1))
  (input  logic                      clk,
   input  logic                      arst_n_i,
   input  logic                      frame_end_i,
   input  ov7670_pkg::color_sel_t    rgbfilter_i,
   output logic [c_nb_img_pxls-1:0]  raddr_o,
   input  ov7670_pkg::pxl_t          rdata_i,
   output logic                      proc_done_o,
   output logic [c_nb_colorpxls-1:0] colorpxls_o,
   output logic [ov7670_pkg::c_hist_bins-1:0][c_nb_bin_cnt-1:0] bin_cnt_o);

  import ov7670_pkg::*;

  localparam int c_nb_bin  = $clog2(c_hist_bins);
  localparam int c_nb_sub  = $clog2(c_bin_cols + 1);
  localparam int c_nb_rows = $clog2(c_in_rows + 1);

  // first inner pixel, and the jump from a row end to the next row start
  localparam logic [c_nb_img_pxls-1:0] c_first_addr =
    c_nb_img_pxls'(c_outframe_rows * c_img_cols + c_outframe_cols);
  localparam logic [c_nb_img_pxls-1:0] c_row_skip = c_nb_img_pxls'(2 * c_outframe_cols + 1);
  localparam logic [c_nb_sub-1:0]  c_last_sub = c_nb_sub'(c_bin_cols - 1);
  localparam logic [c_nb_bin-1:0]  c_last_bin = c_nb_bin'(c_hist_bins - 1);
  localparam logic [c_nb_rows-1:0] c_last_row = c_nb_rows'(c_in_rows - 1);

  typedef enum logic [1:0] {IDLE, SCAN, DRAIN} proc_state_t;

  proc_state_t              state_q;
  logic                     start;
  logic [c_nb_img_pxls-1:0] raddr_q;
  logic [c_nb_rows-1:0]     row_q;
  logic [c_nb_bin-1:0]      bin_q;  // bin of the pixel being addressed
  logic [c_nb_sub-1:0]      sub_q;  // column inside the bin
  logic                     drain_q;
  color_sel_t               filter_q;
  logic                     valid_s1; // rdata_i holds an inner pixel
  logic [c_nb_bin-1:0]      bin_s1;
  logic                     r_hi;
  logic                     g_hi;
  logic                     b_hi;
  logic                     match;

  assign start   = (state_q == IDLE) && frame_end_i; // frame ends in a scan are dropped
  assign raddr_o = raddr_q;

  // address stage, one inner pixel per cycle
  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q     <= IDLE;
      raddr_q     <= '0;
      row_q       <= '0;
      bin_q       <= '0;
      sub_q       <= '0;
      drain_q     <= 1'b0;
      valid_s1    <= 1'b0;
      proc_done_o <= 1'b0;
    end else begin
      proc_done_o <= 1'b0;
      valid_s1    <= (state_q == SCAN);
      case (state_q)
        IDLE: begin
          if (start) begin
            state_q <= SCAN;
            raddr_q <= c_first_addr;
            row_q   <= '0;
            bin_q   <= '0;
            sub_q   <= '0;
          end
        end
        SCAN: begin
          if (sub_q != c_last_sub) begin
            sub_q   <= sub_q + 1'b1;
            raddr_q <= raddr_q + 1'b1;
          end else if (bin_q != c_last_bin) begin
            sub_q   <= '0;
            bin_q   <= bin_q + 1'b1;
            raddr_q <= raddr_q + 1'b1;
          end else begin         // last column of the row
            sub_q   <= '0;
            bin_q   <= '0;
            raddr_q <= raddr_q + c_row_skip;
            if (row_q == c_last_row) begin
              state_q <= DRAIN;
              drain_q <= 1'b0;
            end else begin
              row_q <= row_q + 1'b1;
            end
          end
        end
        DRAIN: begin             // 2 cycles, last read then last count
          drain_q <= ~drain_q;
          if (drain_q) begin
            state_q     <= IDLE;
            proc_done_o <= 1'b1;
          end
        end
        default: state_q <= IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    bin_s1 <= bin_q;           // travels with the read
    if (start)
      filter_q <= rgbfilter_i; // filter fixed for the whole scan
  end

  // classify: selected channel on, both others off
  always_comb begin
    r_hi = rdata_i[11:8] >= c_color_thresh;
    g_hi = rdata_i[7:4]  >= c_color_thresh;
    b_hi = rdata_i[3:0]  >= c_color_thresh;
    case (filter_q)
      c_sel_red:   match = r_hi & ~g_hi & ~b_hi;
      c_sel_green: match = g_hi & ~r_hi & ~b_hi;
      c_sel_blue:  match = b_hi & ~r_hi & ~g_hi;
      default:     match = 1'b0; // no filter
    endcase
  end

  // accumulate stage, counts held until the next scan starts
  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      colorpxls_o <= '0;
      bin_cnt_o   <= '0;
    end else if (start) begin
      colorpxls_o <= '0;
      bin_cnt_o   <= '0;
    end else if (valid_s1 && match) begin
      colorpxls_o      <= colorpxls_o + 1'b1;
      bin_cnt_o[bin_s1] <= bin_cnt_o[bin_s1] + 1'b1;
    end
  end

endmodule

// File: logic/centroid.sv
/*
  centroid
  walks the column histogram one bin per cycle to find the median bin
  and issues it decoded, or zero when too few pixels matched
*/

module centroid
  #(parameter c_nb_colorpxls  = 14,  // width of the total count
    parameter c_nb_bin_cnt    = 11,  // width of each bin count
    parameter c_min_colorpxls = 128) // below this it is taken as noise
  (input  logic                      clk,
   input  logic                      arst_n_i,
   input  logic                      proc_done_i,
   input  logic [c_nb_colorpxls-1:0] colorpxls_i,
   input  logic [ov7670_pkg::c_hist_bins-1:0][c_nb_bin_cnt-1:0] bin_cnt_i,
   output ov7670_pkg::centroid_t     centroid_o,
   output logic                      new_centroid_o);

  import ov7670_pkg::*;

  localparam int c_nb_bin = $clog2(c_hist_bins);
  localparam logic [c_nb_bin-1:0] c_last_bin = c_nb_bin'(c_hist_bins - 1);

  typedef enum logic [1:0] {IDLE, WALK, ISSUE} cent_state_t;

  cent_state_t               state_q;
  logic [c_nb_bin-1:0]       bin_q;   // bin being added
  logic [c_nb_bin-1:0]       med_q;   // median bin once found
  logic                      found_q;
  logic [c_nb_colorpxls-1:0] sum_q;   // running sum of bins before bin_q
  logic [c_nb_colorpxls-1:0] sum_nxt;
  logic                      hit;
  logic [c_nb_bin-1:0]       med_nxt;

  // median: first bin where twice the running sum reaches the total
  always_comb begin
    sum_nxt = sum_q + c_nb_colorpxls'(bin_cnt_i[bin_q]);
    hit     = !found_q && ({sum_nxt, 1'b0} >= {1'b0, colorpxls_i});
    med_nxt = hit ? bin_q : med_q;
  end

  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q    <= IDLE;
      bin_q      <= '0;
      med_q      <= '0;
      found_q    <= 1'b0;
      sum_q      <= '0;
      centroid_o <= '0;
    end else begin
      case (state_q)
        IDLE: begin
          if (proc_done_i) begin
            state_q <= WALK;
            bin_q   <= '0;
            sum_q   <= '0;
            found_q <= 1'b0;
          end
        end
        WALK: begin
          sum_q <= sum_nxt;
          bin_q <= bin_q + 1'b1;
          if (hit) begin
            found_q <= 1'b1;
            med_q   <= bin_q;
          end
          if (bin_q == c_last_bin) begin // all bins seen, update output
            state_q <= ISSUE;
            if (colorpxls_i < c_nb_colorpxls'(c_min_colorpxls))
              centroid_o <= '0;
            else
              centroid_o <= centroid_t'(1) << med_nxt;
          end
        end
        ISSUE:   state_q <= IDLE; // one cycle strobe
        default: state_q <= IDLE;
      endcase
    end
  end

  assign new_centroid_o = (state_q == ISSUE);

endmodule

// File: logic/top_ov7670_centroid.sv
/*
  single camera colour tracker top level
  ov7670 capture into a frame buffer, colour histogram of the inner
  frame and decoded centroid of the selected colour
*/

module top_ov7670_centroid
  #(parameter  c_img_cols      = 160, // qqvga
    parameter  c_img_rows      = 120,
    parameter  c_outframe_cols = 16,
    parameter  c_outframe_rows = 8,
    parameter  c_min_colorpxls = 128,
    localparam c_img_pxls      = c_img_cols * c_img_rows,
    localparam c_nb_img_pxls   = $clog2(c_img_pxls),
    localparam c_in_cols       = c_img_cols - 2 * c_outframe_cols,
    localparam c_in_rows       = c_img_rows - 2 * c_outframe_rows,
    localparam c_bin_cols      = c_in_cols / ov7670_pkg::c_hist_bins,
    localparam c_nb_colorpxls  = $clog2(c_in_cols * c_in_rows + 1),
    localparam c_nb_bin_cnt    = $clog2(c_in_rows * c_bin_cols + 1))
  (input  logic                      clk,
   input  logic                      arst_n_i,
   input  logic                      ov7670_pclk_i,
   input  logic                      ov7670_vsync_i,
   input  logic                      ov7670_href_i,
   input  ov7670_pkg::cam_byte_t     ov7670_d_i,
   input  ov7670_pkg::color_sel_t    rgbfilter_i,
   output ov7670_pkg::centroid_t     centroid_o,
   output logic                      new_centroid_o,
   output logic [c_nb_colorpxls-1:0] colorpxls_o);

  import ov7670_pkg::*;

  logic                     capture_we;
  logic [c_nb_img_pxls-1:0] capture_addr;
  pxl_t                     capture_pxl;
  logic                     frame_end;
  logic [c_nb_img_pxls-1:0] orig_img_addr;
  pxl_t                     orig_img_pxl;
  logic                     proc_done;
  logic [c_hist_bins-1:0][c_nb_bin_cnt-1:0] bin_cnt; // histogram

  ov7670_capture #(
    .c_img_cols (c_img_cols),
    .c_img_rows (c_img_rows)
  ) i_capture (
    .clk         (clk),
    .arst_n_i    (arst_n_i),
    .pclk_i      (ov7670_pclk_i),
    .vsync_i     (ov7670_vsync_i),
    .href_i      (ov7670_href_i),
    .data_i      (ov7670_d_i),
    .we_o        (capture_we),
    .addr_o      (capture_addr),
    .pxl_o       (capture_pxl),
    .frame_end_o (frame_end)
  );

  // camera image, written by capture and read by processing
  frame_buffer #(
    .c_img_pxls (c_img_pxls)
  ) i_cam_fb (
    .clk     (clk),
    .we_i    (capture_we),
    .waddr_i (capture_addr),
    .wdata_i (capture_pxl),
    .raddr_i (orig_img_addr),
    .rdata_o (orig_img_pxl)
  );

  color_proc #(
    .c_img_cols      (c_img_cols),
    .c_img_rows      (c_img_rows),
    .c_outframe_cols (c_outframe_cols),
    .c_outframe_rows (c_outframe_rows)
  ) i_color_proc (
    .clk         (clk),
    .arst_n_i    (arst_n_i),
    .frame_end_i (frame_end),
    .rgbfilter_i (rgbfilter_i),
    .raddr_o     (orig_img_addr),
    .rdata_i     (orig_img_pxl),
    .proc_done_o (proc_done),
    .colorpxls_o (colorpxls_o),
    .bin_cnt_o   (bin_cnt)
  );

  centroid #(
    .c_nb_colorpxls  (c_nb_colorpxls),
    .c_nb_bin_cnt    (c_nb_bin_cnt),
    .c_min_colorpxls (c_min_colorpxls)
  ) i_centroid (
    .clk            (clk),
    .arst_n_i       (arst_n_i),
    .proc_done_i    (proc_done),
    .colorpxls_i    (colorpxls_o),
    .bin_cnt_i      (bin_cnt),
    .centroid_o     (centroid_o),
    .new_centroid_o (new_centroid_o)
  );

endmodule

// File: dv/tb_clkgen.sv
/*
  testbench clock generator
  free running clock, starts low
*/

module tb_clkgen
  #(parameter int c_period_ns = 4)
  (output logic clk_o);

  timeunit 1ns;
  timeprecision 100ps;

  initial clk_o = 1'b0;

  always #(c_period_ns / 2.0) clk_o = ~clk_o; // half period per toggle

endmodule

// File: dv/centroid_props.sv
/*
  colour tracker properties
  strobe width, decoded centroid shape and capture address range
*/

module centroid_props
  #(parameter  c_img_pxls = 768,
    localparam c_nb_addr  = $clog2(c_img_pxls))
  (input logic                 clk,
   input logic                 arst_n_i,
   input logic                 new_centroid_i,
   input logic [7:0]           centroid_i,
   input logic                 we_i,
   input logic [c_nb_addr-1:0] waddr_i);

  timeunit 1ns;
  timeprecision 100ps;

  // result strobe is a single cycle pulse
  a_single_strobe : assert property (@(posedge clk) disable iff (!arst_n_i)
    new_centroid_i |=> !new_centroid_i)
    else $error("new_centroid_o stayed high for more than one cycle");

  // decoded centroid, at most one bin set
  a_onehot_centroid : assert property (@(posedge clk) disable iff (!arst_n_i)
    $onehot0(centroid_i))
    else $error("centroid_o has more than one bit set");

  a_waddr_range : assert property (@(posedge clk) disable iff (!arst_n_i)
    waddr_i < c_img_pxls) // clamped at the last pixel
    else $error("capture write address beyond the frame buffer");

endmodule

// File: dv/tb_top.sv
/*
  colour tracker testbench
  reads scenes from the case file, sends them as rgb565 camera frames
  and checks the pixel count and decoded centroid of each frame
*/

module tb_top;

  timeunit 1ns;
  timeprecision 100ps;

  import ov7670_pkg::*;

  localparam int c_cols        = 32;
  localparam int c_rows        = 24;
  localparam int c_frame_bytes = c_cols * c_rows * 2; // two bytes per pixel
  localparam int c_nb_colorpxls = $clog2((c_cols - 8) * (c_rows - 4) + 1);
  localparam int c_wait_max    = 2000;                // cycles to new_centroid_o

  typedef struct {
    int filt;
    int bg;        // background, rgb565
    int fg;        // rectangle colour, rgb565
    int c0;
    int c1;
    int r0;
    int r1;
    int exp_px;
    int exp_cent;
  } case_t;

  logic                      clk;
  logic                      arst_n;
  logic                      pclk;
  logic                      vsync;
  logic                      href;
  cam_byte_t                 cam_d;
  color_sel_t                rgbfilter;
  centroid_t                 centroid;
  logic                      new_centroid;
  logic [c_nb_colorpxls-1:0] colorpxls;

  case_t cases[$];
  bit    cases_loaded = 1'b0;
  int    checks = 0;
  int    errors = 0;

  tb_clkgen #(.c_period_ns(4)) clkgen_i (.clk_o(clk));

  top_ov7670_centroid #(
    .c_img_cols      (c_cols),
    .c_img_rows      (c_rows),
    .c_outframe_cols (4),
    .c_outframe_rows (2),
    .c_min_colorpxls (16)
  ) dut_i (
    .clk            (clk),
    .arst_n_i       (arst_n),
    .ov7670_pclk_i  (pclk),
    .ov7670_vsync_i (vsync),
    .ov7670_href_i  (href),
    .ov7670_d_i     (cam_d),
    .rgbfilter_i    (rgbfilter),
    .centroid_o     (centroid),
    .new_centroid_o (new_centroid),
    .colorpxls_o    (colorpxls)
  );

  bind top_ov7670_centroid centroid_props #(.c_img_pxls(c_img_pxls)) props_i (
    .clk            (clk),
    .arst_n_i       (arst_n_i),
    .new_centroid_i (new_centroid_o),
    .centroid_i     (centroid_o),
    .we_i           (capture_we),
    .waddr_i        (capture_addr)
  );

  // inputs change 1 ns after the rising edge
  task automatic next_cycles(input int n);
    repeat (n) @(posedge clk);
    #1;
  endtask

  task automatic load_cases();
    int    fd;
    int    n;
    string line;
    case_t tc;
    fd = $fopen("dv/centroid_cases.txt", "r");
    if (fd == 0) begin
      $display("could not open the case file dv/centroid_cases.txt");
      errors++;
    end else begin
      while ($fgets(line, fd) != 0) begin
        if (line.len() < 2 || line.getc(0) == "#")
          continue;                                // comment or blank line
        n = $sscanf(line, "%h %h %h %d %d %d %d %d %h", tc.filt, tc.bg, tc.fg,
                    tc.c0, tc.c1, tc.r0, tc.r1, tc.exp_px, tc.exp_cent);
        if (n == 9) begin
          cases.push_back(tc);
        end else begin
          $display("case file line could not be parsed: %s", line);
          errors++;
        end
      end
      $fclose(fd);
    end
  endtask

  task automatic check_value(input string name, input int expected, input int actual);
    checks++;
    assert (actual == expected) else begin
      $display("[FAIL] %0t %s expected %0d (h%0h) got %0d (h%0h)",
               $time, name, expected, expected, actual, actual);
      errors++;
    end
  endtask

  // scene colour at one pixel, rectangle over background
  function automatic logic [15:0] pixel_at(input case_t tc, input int c, input int r);
    if (c >= tc.c0 && c <= tc.c1 && r >= tc.r0 && r <= tc.r1)
      return tc.fg[15:0];
    return tc.bg[15:0];
  endfunction

  // data set while pclk is low, taken on the rise
  task automatic send_byte(input cam_byte_t b);
    pclk  = 1'b0;
    cam_d = b;
    next_cycles(2);
    pclk  = 1'b1;
    next_cycles(2);
  endtask

  task automatic send_frame(input case_t tc);
    logic [15:0] px;
    for (int r = 0; r < c_rows; r++) begin
      href = 1'b1;
      for (int c = 0; c < c_cols; c++) begin
        px = pixel_at(tc, c, r);
        send_byte(px[15:8]); // r[4:0] g[5:3]
        send_byte(px[7:0]);  // g[2:0] b[4:0]
      end
      pclk = 1'b0;
      href = 1'b0;
      next_cycles(4);        // line blanking
    end
  endtask

  task automatic send_vsync();
    vsync = 1'b1;
    next_cycles(8);
    vsync = 1'b0;
    next_cycles(4);
  endtask

  task automatic run_case(input int idx, input case_t tc);
    bit seen;
    rgbfilter = tc.filt[1:0]; // latched when the scan starts
    send_frame(tc);
    send_vsync();             // closes the frame, starts processing
    seen = 1'b0;
    for (int n = 0; n < c_wait_max && !seen; n++) begin
      next_cycles(1);
      seen = new_centroid;
    end
    checks++;
    assert (seen) else begin
      $display("no new_centroid_o pulse for case %0d within %0d cycles", idx, c_wait_max);
      errors++;
    end
    if (seen) begin
      check_value($sformatf("colorpxls_o (case %0d)", idx), tc.exp_px, colorpxls);
      check_value($sformatf("centroid_o (case %0d)", idx), tc.exp_cent, centroid);
    end
  endtask

  initial begin
    arst_n    = 1'b0;
    pclk      = 1'b0;
    vsync     = 1'b0;
    href      = 1'b0;
    cam_d     = '0;
    rgbfilter = c_sel_red;
    load_cases();
    cases_loaded = 1'b1;
    checks++;
    assert (cases.size() > 0) else begin
      $display("no cases read from the case file");
      errors++;
    end
    repeat (16) @(posedge clk);
    #1 arst_n = 1'b1;
    next_cycles(2);
    check_value("new_centroid_o", 0, new_centroid); // idle after reset
    check_value("centroid_o", 0, centroid);
    check_value("colorpxls_o", 0, colorpxls);
    send_vsync();               // nothing written yet, no frame end
    foreach (cases[i])
      run_case(i, cases[i]);
    $display("checks %0d, errors %0d", checks, errors);
    if (errors == 0)
      $display("Test completed successfully");
    else
      $display("Test failed");
    $finish;
  end

  // watchdog, bound from the case count and the frame length
  initial begin
    wait (cases_loaded);
    repeat ((cases.size() + 2) * (c_frame_bytes * 4 + 2000)) @(posedge clk);
    $display("timeout, the run did not finish in the expected time");
    $display("checks %0d, errors %0d", checks, errors);
    $display("Test failed");
    $finish;
  end

endmodule

// File: dv/centroid_cases.txt
# filter bg fg (rgb565) and centroid in hex; rectangle cols, rows and pixel count in decimal
# filter bg   fg   col0 col1 row0 row1 exp_colorpxls exp_centroid
0 0000 f800 10 12  5 10  18 04
0 0000 f800  7 21  3  6  60 08
0 0000 f800 19 27  2 21 180 40
0 0000 f800 13 16  8 11  16 08
0 0000 f800  0  6  0 23  60 01
0 0000 f800 22 31 15 23  42 40
0 0000 f800  0  3  0 23   0 00
0 0000 f800  0 31 22 23   0 00
0 0000 f800 13 15  8 12  15 00
1 0000 f800 10 12  5 10   0 00
2 0000 f800 10 12  5 10   0 00
3 0000 f800 10 12  5 10   0 00
1 0000 07e0 16 18  2 21  60 10
0 0000 07e0 16 18  2 21   0 00
2 0000 001f  4  9  2  4  18 01
0 8410 f800 10 12  5 10  18 04
0 8000 7800  0 31  0 23   0 00
0 7800 8000  4 27  2 21 480 08

// File: flist.f
logic/ov7670_pkg.sv
logic/ov7670_capture.sv
logic/frame_buffer.sv
logic/color_proc.sv
logic/centroid.sv
logic/top_ov7670_centroid.sv
dv/tb_clkgen.sv
dv/centroid_props.sv
dv/tb_top.sv
